// ==== logic/rv_core_params.svh ====
// Core parameter macros
`ifndef RV_CORE_PARAMS_SVH
`define RV_CORE_PARAMS_SVH

// Data and address width
`define RV_XLEN 32

// Architectural register count
`define RV_NUM_REGS 32

// Load address answered by the keypad scanner
`define RV_KEYPAD_ADDR 32'h0000_1000

// Clock cycles each keypad column stays driven
`define RV_SCAN_DIV 16

`endif

// ==== logic/rv_core_pkg.sv ====
// Core types and encodings
`include "rv_core_params.svh"

package rv_core_pkg;

  // Major opcodes of the supported subset
  typedef enum logic [6:0] {
    OP_REG    = 7'b0110011,
    OP_IMM    = 7'b0010011,
    OP_LUI    = 7'b0110111,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_BRANCH = 7'b1100011,
    OP_JAL    = 7'b1101111
  } rv_opcode_e;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_PASS_B
  } rv_alu_op_e;

  // Sequencer states
  typedef enum logic [1:0] {
    ST_FETCH,
    ST_EXEC,
    ST_MEM
  } rv_state_e;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } rv_fmt_r_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } rv_fmt_i_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } rv_fmt_s_t;

  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } rv_fmt_b_t;

  typedef struct packed {
    logic [19:0] imm;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } rv_fmt_u_t;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } rv_fmt_j_t;

  // One instruction word, viewed per format
  typedef union packed {
    rv_fmt_r_t r;
    rv_fmt_i_t i;
    rv_fmt_s_t s;
    rv_fmt_b_t b;
    rv_fmt_u_t u;
    rv_fmt_j_t j;
  } rv_instr_u;

  typedef struct packed {
    rv_alu_op_e alu_op;
    logic       alu_src_imm;
    logic       reg_write;
    logic       mem_read;
    logic       mem_write;
    logic       branch_eq;
    logic       branch_ne;
    logic       jump;
    logic       lui;
  } rv_ctrl_t;

  // Data access from the datapath
  typedef struct packed {
    logic [`RV_XLEN-1:0] addr;
    logic [`RV_XLEN-1:0] wdata;
    logic                read;
    logic                write;
  } rv_mem_req_t;

  // Outgoing bus request
  typedef struct packed {
    logic [`RV_XLEN-1:0] adr;
    logic [`RV_XLEN-1:0] dat;
    logic [3:0]          sel;
    logic                read;
    logic                write;
  } rv_bus_req_t;

endpackage

// ==== logic/instr_decoder.sv ====
// Instruction decoder
`timescale 1ns/1ps
`include "rv_core_params.svh"

module instr_decoder (
  input  rv_core_pkg::rv_instr_u instr_i,
  output rv_core_pkg::rv_ctrl_t  ctrl_o,
  output logic [`RV_XLEN-1:0]    imm_o
);
  import rv_core_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;

  assign opcode = instr_i.r.opcode;
  assign funct3 = instr_i.i.funct3;

  // Sign-extended immediate, format picked by opcode
  always_comb begin
    case (opcode)
      OP_IMM, OP_LOAD: begin
        imm_o = {{(`RV_XLEN-12){instr_i.i.imm[11]}}, instr_i.i.imm};
      end
      OP_STORE: begin
        imm_o = {{(`RV_XLEN-12){instr_i.s.imm_hi[6]}}, instr_i.s.imm_hi, instr_i.s.imm_lo};
      end
      OP_BRANCH: begin
        imm_o = {{(`RV_XLEN-12){instr_i.b.imm12}}, instr_i.b.imm11,
                 instr_i.b.imm10_5, instr_i.b.imm4_1, 1'b0};
      end
      OP_LUI: begin
        imm_o = {instr_i.u.imm, 12'b0};
      end
      OP_JAL: begin
        imm_o = {{(`RV_XLEN-20){instr_i.j.imm20}}, instr_i.j.imm19_12,
                 instr_i.j.imm11, instr_i.j.imm10_1, 1'b0};
      end
      default: begin
        imm_o = '0;
      end
    endcase
  end

  // Control bits; anything unknown stays all zero
  always_comb begin
    ctrl_o = '0;
    case (opcode)
      OP_REG: begin
        ctrl_o.reg_write = 1'b1;
        case (funct3)
          3'b000:  ctrl_o.alu_op = instr_i.r.funct7[5] ? ALU_SUB : ALU_ADD;
          3'b010:  ctrl_o.alu_op = ALU_SLT;
          3'b100:  ctrl_o.alu_op = ALU_XOR;
          3'b110:  ctrl_o.alu_op = ALU_OR;
          3'b111:  ctrl_o.alu_op = ALU_AND;
          default: ctrl_o = '0;
        endcase
      end
      OP_IMM: begin
        ctrl_o.reg_write   = 1'b1;
        ctrl_o.alu_src_imm = 1'b1;
        case (funct3)
          3'b000:  ctrl_o.alu_op = ALU_ADD;
          3'b100:  ctrl_o.alu_op = ALU_XOR;
          3'b110:  ctrl_o.alu_op = ALU_OR;
          3'b111:  ctrl_o.alu_op = ALU_AND;
          default: ctrl_o = '0;
        endcase
      end
      OP_LUI: begin
        ctrl_o.reg_write   = 1'b1;
        ctrl_o.alu_src_imm = 1'b1;
        ctrl_o.alu_op      = ALU_PASS_B;
        ctrl_o.lui         = 1'b1;
      end
      OP_LOAD: begin
        if (funct3 == 3'b010) begin
          ctrl_o.reg_write   = 1'b1;
          ctrl_o.alu_src_imm = 1'b1;
          ctrl_o.mem_read    = 1'b1;
        end
      end
      OP_STORE: begin
        if (funct3 == 3'b010) begin
          ctrl_o.alu_src_imm = 1'b1;
          ctrl_o.mem_write   = 1'b1;
        end
      end
      OP_BRANCH: begin
        ctrl_o.alu_op    = ALU_SUB;
        ctrl_o.branch_eq = (funct3 == 3'b000);
        ctrl_o.branch_ne = (funct3 == 3'b001);
      end
      OP_JAL: begin
        ctrl_o.reg_write = 1'b1;
        ctrl_o.jump      = 1'b1;
      end
      default: begin
        ctrl_o = '0;
      end
    endcase
  end

endmodule

// ==== logic/reg_file.sv ====
// Integer register file
`timescale 1ns/1ps
`include "rv_core_params.svh"

module reg_file (
  input  logic                clk,
  input  logic                rst_n_i,
  input  logic [4:0]          rs1_i,
  input  logic [4:0]          rs2_i,
  input  logic [4:0]          rd_i,
  input  logic                rd_we_i,
  input  logic [`RV_XLEN-1:0] rd_data_i,
  output logic [`RV_XLEN-1:0] rs1_data_o,
  output logic [`RV_XLEN-1:0] rs2_data_o
);

  logic [`RV_XLEN-1:0] regs [`RV_NUM_REGS];

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      for (int k = 0; k < `RV_NUM_REGS; k++) begin
        regs[k] <= '0;
      end
    end else if (rd_we_i && (rd_i != 5'd0)) begin
      regs[rd_i] <= rd_data_i;
    end
  end

  // x0 is hardwired to zero
  assign rs1_data_o = (rs1_i == 5'd0) ? '0 : regs[rs1_i];
  assign rs2_data_o = (rs2_i == 5'd0) ? '0 : regs[rs2_i];

endmodule

// ==== logic/core_datapath.sv ====
// Multi-cycle core datapath
`timescale 1ns/1ps
`include "rv_core_params.svh"

module core_datapath (
  input  logic                    clk,
  input  logic                    rst_n_i,
  input  logic                    ihit_i,
  input  logic                    dhit_i,
  input  logic [`RV_XLEN-1:0]     rdata_i,
  input  rv_core_pkg::rv_ctrl_t   ctrl_i,
  input  logic [`RV_XLEN-1:0]     imm_i,
  input  logic [`RV_XLEN-1:0]     rs1_data_i,
  input  logic [`RV_XLEN-1:0]     rs2_data_i,
  output rv_core_pkg::rv_instr_u  instr_o,
  output logic                    fetch_req_o,
  output logic [`RV_XLEN-1:0]     fetch_addr_o,
  output rv_core_pkg::rv_mem_req_t mem_req_o,
  output logic                    rd_we_o,
  output logic [`RV_XLEN-1:0]     rd_data_o
);
  import rv_core_pkg::*;

  rv_state_e           state;
  logic [`RV_XLEN-1:0] pc;
  logic [`RV_XLEN-1:0] pc_plus4;
  logic [`RV_XLEN-1:0] next_pc;
  logic [`RV_XLEN-1:0] alu_a;
  logic [`RV_XLEN-1:0] alu_b;
  logic [`RV_XLEN-1:0] alu_result;
  logic                taken;
  logic                is_mem;

  // ALU operands; lui ignores rs1 entirely
  assign alu_a = ctrl_i.lui ? '0 : rs1_data_i;
  assign alu_b = ctrl_i.alu_src_imm ? imm_i : rs2_data_i;

  always_comb begin
    case (ctrl_i.alu_op)
      ALU_ADD:    alu_result = alu_a + alu_b;
      ALU_SUB:    alu_result = alu_a - alu_b;
      ALU_AND:    alu_result = alu_a & alu_b;
      ALU_OR:     alu_result = alu_a | alu_b;
      ALU_XOR:    alu_result = alu_a ^ alu_b;
      ALU_SLT:    alu_result = {{(`RV_XLEN-1){1'b0}}, $signed(alu_a) < $signed(alu_b)};
      ALU_PASS_B: alu_result = alu_b;
      default:    alu_result = alu_a + alu_b;
    endcase
  end

  // Branch compare works on the raw register values
  assign taken = (ctrl_i.branch_eq && (rs1_data_i == rs2_data_i)) ||
                 (ctrl_i.branch_ne && (rs1_data_i != rs2_data_i)) ||
                 ctrl_i.jump;
  assign pc_plus4 = pc + `RV_XLEN'd4;
  assign next_pc  = taken ? (pc + imm_i) : pc_plus4;
  assign is_mem   = ctrl_i.mem_read || ctrl_i.mem_write;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state           <= ST_FETCH;
      pc              <= '0;
      fetch_req_o     <= 1'b0;
      mem_req_o.read  <= 1'b0;
      mem_req_o.write <= 1'b0;
    end else begin
      case (state)
        ST_FETCH: begin
          if (ihit_i) begin
            instr_o     <= rdata_i;
            fetch_req_o <= 1'b0;
            state       <= ST_EXEC;
          end else begin
            fetch_req_o <= 1'b1;
          end
        end
        ST_EXEC: begin
          pc <= next_pc;
          if (is_mem) begin
            mem_req_o.addr  <= alu_result;
            mem_req_o.wdata <= rs2_data_i;
            mem_req_o.read  <= ctrl_i.mem_read;
            mem_req_o.write <= ctrl_i.mem_write;
            state           <= ST_MEM;
          end else begin
            fetch_req_o <= 1'b1;
            state       <= ST_FETCH;
          end
        end
        ST_MEM: begin
          // Hold the access until the request unit answers
          if (dhit_i) begin
            mem_req_o.read  <= 1'b0;
            mem_req_o.write <= 1'b0;
            fetch_req_o     <= 1'b1;
            state           <= ST_FETCH;
          end
        end
        default: begin
          state <= ST_FETCH;
        end
      endcase
    end
  end

  assign fetch_addr_o = pc;

  // Writeback in execute, or on the load's completion cycle
  assign rd_we_o = ((state == ST_EXEC) && ctrl_i.reg_write && !ctrl_i.mem_read) ||
                   ((state == ST_MEM) && dhit_i && ctrl_i.mem_read);
  assign rd_data_o = (state == ST_MEM) ? rdata_i :
                     ctrl_i.jump       ? pc_plus4 : alu_result;

endmodule

// ==== logic/request_unit.sv ====
// Bus and keypad request unit
`timescale 1ns/1ps
`include "rv_core_params.svh"

module request_unit (
  input  logic                     clk,
  input  logic                     rst_n_i,
  input  logic                     fetch_req_i,
  input  logic [`RV_XLEN-1:0]      fetch_addr_i,
  input  rv_core_pkg::rv_mem_req_t mem_req_i,
  output logic                     ihit_o,
  output logic                     dhit_o,
  output logic [`RV_XLEN-1:0]      rdata_o,
  input  logic [4:0]               key_event_i,
  output logic                     key_pop_o,
  output rv_core_pkg::rv_bus_req_t bus_req_o,
  input  logic                     bus_busy_i,
  input  logic [`RV_XLEN-1:0]      bus_rdata_i
);
  import rv_core_pkg::*;

  rv_bus_req_t bus_req_q;
  logic        pend_fetch;
  logic        active;
  logic        bus_done;
  logic        data_req;
  logic        key_sel;
  logic        key_access;

  assign active   = bus_req_q.read || bus_req_q.write;
  assign bus_done = active && !bus_busy_i;
  assign data_req = mem_req_i.read || mem_req_i.write;
  assign key_sel  = (mem_req_i.addr == `RV_KEYPAD_ADDR);

  // Keypad accesses are answered locally while the bus is idle
  assign key_access = !active && data_req && key_sel;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      bus_req_q.read  <= 1'b0;
      bus_req_q.write <= 1'b0;
      pend_fetch      <= 1'b0;
    end else if (active) begin
      // Everything stays put until the slave drops busy
      if (!bus_busy_i) begin
        bus_req_q.read  <= 1'b0;
        bus_req_q.write <= 1'b0;
      end
    end else if (fetch_req_i) begin
      bus_req_q.adr   <= fetch_addr_i;
      bus_req_q.dat   <= '0;
      bus_req_q.sel   <= 4'hf;
      bus_req_q.read  <= 1'b1;
      bus_req_q.write <= 1'b0;
      pend_fetch      <= 1'b1;
    end else if (data_req && !key_sel) begin
      bus_req_q.adr   <= mem_req_i.addr;
      bus_req_q.dat   <= mem_req_i.wdata;
      bus_req_q.sel   <= 4'hf;
      bus_req_q.read  <= mem_req_i.read;
      bus_req_q.write <= mem_req_i.write;
      pend_fetch      <= 1'b0;
    end
  end

  assign bus_req_o = bus_req_q;

  assign ihit_o    = bus_done && pend_fetch;
  assign dhit_o    = (bus_done && !pend_fetch) || key_access;
  assign key_pop_o = key_access && mem_req_i.read;

  // Key event sits in the low bits, rest zero
  assign rdata_o = key_access ? {{(`RV_XLEN-5){1'b0}}, key_event_i} : bus_rdata_i;

endmodule

// ==== logic/keypad_scanner.sv ====
// 4x4 keypad scanner
`timescale 1ns/1ps
`include "rv_core_params.svh"

module keypad_scanner #(
  parameter int SCAN_DIV = `RV_SCAN_DIV
) (
  input  logic       clk,
  input  logic       rst_n_i,
  input  logic [3:0] rows_i,
  output logic [3:0] cols_o,
  input  logic       key_pop_i,
  output logic [4:0] key_event_o
);

  logic [$clog2(SCAN_DIV)-1:0] div_cnt;
  logic [1:0] col_idx;
  logic       col_step;
  logic [3:0] rows_meta;
  logic [3:0] rows_sync;
  logic       row_low;
  logic [1:0] row_idx;
  logic       scan_low;
  logic       pressed;
  logic       valid;
  logic [3:0] code;

  assign col_step = (div_cnt == SCAN_DIV - 1);
  assign row_low  = (rows_sync != 4'hf);

  // Lowest active row wins
  always_comb begin
    if (!rows_sync[0]) row_idx = 2'd0;
    else if (!rows_sync[1]) row_idx = 2'd1;
    else if (!rows_sync[2]) row_idx = 2'd2;
    else row_idx = 2'd3;
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      div_cnt   <= '0;
      col_idx   <= 2'd0;
      rows_meta <= 4'hf;
      rows_sync <= 4'hf;
      scan_low  <= 1'b0;
      pressed   <= 1'b0;
      valid     <= 1'b0;
      code      <= '0;
    end else begin
      rows_meta <= rows_i;
      rows_sync <= rows_meta;
      if (key_pop_i) begin
        valid <= 1'b0;
      end
      if (col_step) begin
        div_cnt <= '0;
        col_idx <= col_idx + 2'd1;
        // Rows are sampled at the end of each column slot
        if (row_low && !pressed) begin
          code    <= {row_idx, col_idx};
          valid   <= 1'b1;
          pressed <= 1'b1;
        end
        if (col_idx == 2'd3) begin
          scan_low <= 1'b0;
          if (!(scan_low || row_low)) begin
            pressed <= 1'b0;
          end
        end else begin
          scan_low <= scan_low || row_low;
        end
      end else begin
        div_cnt <= div_cnt + 1'b1;
      end
    end
  end

  // One column pulled low at a time
  assign cols_o      = ~(4'b0001 << col_idx);
  assign key_event_o = {valid, code};

endmodule

// ==== logic/rv_cpu.sv ====
// RV32I subset processor top
`timescale 1ns/1ps
`include "rv_core_params.svh"

module rv_cpu (
  input  logic                     clk,
  input  logic                     rst_n_i,
  input  logic                     bus_busy_i,
  input  logic [`RV_XLEN-1:0]      bus_rdata_i,
  input  logic [3:0]               rows_i,
  output rv_core_pkg::rv_bus_req_t bus_req_o,
  output logic [3:0]               cols_o
);
  import rv_core_pkg::*;

  rv_instr_u           instr;
  rv_ctrl_t            ctrl;
  rv_mem_req_t         mem_req;
  logic [`RV_XLEN-1:0] imm;
  logic [`RV_XLEN-1:0] rs1_data;
  logic [`RV_XLEN-1:0] rs2_data;
  logic [`RV_XLEN-1:0] rd_data;
  logic [`RV_XLEN-1:0] fetch_addr;
  logic [`RV_XLEN-1:0] rdata;
  logic                rd_we;
  logic                fetch_req;
  logic                ihit;
  logic                dhit;
  logic [4:0]          key_event;
  logic                key_pop;

  instr_decoder instr_decoder_inst (
    .instr_i (instr),
    .ctrl_o  (ctrl),
    .imm_o   (imm)
  );

  reg_file reg_file_inst (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .rs1_i      (instr.r.rs1),
    .rs2_i      (instr.r.rs2),
    .rd_i       (instr.r.rd),
    .rd_we_i    (rd_we),
    .rd_data_i  (rd_data),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data)
  );

  core_datapath core_datapath_inst (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .ihit_i       (ihit),
    .dhit_i       (dhit),
    .rdata_i      (rdata),
    .ctrl_i       (ctrl),
    .imm_i        (imm),
    .rs1_data_i   (rs1_data),
    .rs2_data_i   (rs2_data),
    .instr_o      (instr),
    .fetch_req_o  (fetch_req),
    .fetch_addr_o (fetch_addr),
    .mem_req_o    (mem_req),
    .rd_we_o      (rd_we),
    .rd_data_o    (rd_data)
  );

  request_unit request_unit_inst (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .fetch_req_i  (fetch_req),
    .fetch_addr_i (fetch_addr),
    .mem_req_i    (mem_req),
    .ihit_o       (ihit),
    .dhit_o       (dhit),
    .rdata_o      (rdata),
    .key_event_i  (key_event),
    .key_pop_o    (key_pop),
    .bus_req_o    (bus_req_o),
    .bus_busy_i   (bus_busy_i),
    .bus_rdata_i  (bus_rdata_i)
  );

  keypad_scanner #(
    .SCAN_DIV (`RV_SCAN_DIV)
  ) keypad_scanner_inst (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .rows_i      (rows_i),
    .cols_o      (cols_o),
    .key_pop_i   (key_pop),
    .key_event_o (key_event)
  );

endmodule

// ==== verif/rv_iss_model.svh ====
// Reference model and program generator
`ifndef RV_ISS_MODEL_SVH
`define RV_ISS_MODEL_SVH

function automatic int rand_range(input int n);
  return int'($unsigned($random(seed)) % $unsigned(n));
endfunction

// RV32I encodings for each format
function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3,
                                       input logic [4:0] rd);
  return {f7, rs2, rs1, f3, rd, 7'b0110011};
endfunction

function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                       input logic [2:0] f3, input logic [4:0] rd,
                                       input logic [6:0] op);
  return {imm, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                       input logic [4:0] rs1);
  return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
endfunction

function automatic logic [31:0] b_type(input logic [12:0] off, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3);
  return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
endfunction

function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd);
  return {imm, rd, 7'b0110111};
endfunction

function automatic logic [31:0] j_type(input logic [20:0] off, input logic [4:0] rd);
  return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
endfunction

// x1 holds the data base, so it is never a random destination
function automatic logic [4:0] pick_rd();
  int r;
  r = rand_range(12) + 1;
  return (r == 1) ? 5'd0 : 5'(r);
endfunction

function automatic logic [4:0] pick_rs();
  return 5'(rand_range(13));
endfunction

task automatic put_word(input logic [31:0] word);
  mem[prog_len]     = word;
  ref_mem[prog_len] = word;
  prog_len++;
endtask

task automatic put_alu();
  logic [4:0]  rd;
  logic [11:0] imm;
  rd  = pick_rd();
  imm = 12'(rand_range(4096));
  case (rand_range(11))
    0: put_word(r_type(7'h00, pick_rs(), pick_rs(), 3'b000, rd));
    1: put_word(r_type(7'h20, pick_rs(), pick_rs(), 3'b000, rd));
    2: put_word(r_type(7'h00, pick_rs(), pick_rs(), 3'b111, rd));
    3: put_word(r_type(7'h00, pick_rs(), pick_rs(), 3'b110, rd));
    4: put_word(r_type(7'h00, pick_rs(), pick_rs(), 3'b100, rd));
    5: put_word(r_type(7'h00, pick_rs(), pick_rs(), 3'b010, rd));
    6: put_word(i_type(imm, pick_rs(), 3'b000, rd, 7'b0010011));
    7: put_word(i_type(imm, pick_rs(), 3'b111, rd, 7'b0010011));
    8: put_word(i_type(imm, pick_rs(), 3'b110, rd, 7'b0010011));
    9: put_word(i_type(imm, pick_rs(), 3'b100, rd, 7'b0010011));
    default: put_word(u_type(20'(rand_range(1 << 20)), rd));
  endcase
endtask

task automatic build_program();
  int         jal_at;
  int         skip;
  int         sel;
  logic [4:0] link;
  for (int i = 0; i < MEM_WORDS; i++) begin
    mem[i]     = 32'hc3a5_0000 | 32'(i * 4);
    ref_mem[i] = mem[i];
  end
  prog_len = 0;
  put_word(u_type(20'h00002, 5'd1));
  put_word(u_type(20'(`RV_KEYPAD_ADDR >> 12), 5'd15));
  jal_at = 5 + rand_range(40);
  for (int k = 0; k < 60; k++) begin
    sel = rand_range(10);
    if (k == jal_at) begin
      // Jump over one word, then store the link value
      link = 5'(2 + rand_range(11));
      put_word(j_type(21'd8, link));
      put_alu();
      put_word(s_type(12'd64, link, 5'd1));
    end else if (sel < 6) begin
      put_alu();
    end else if (sel == 6) begin
      put_word(s_type(12'(rand_range(16) * 4), pick_rs(), 5'd1));
    end else if (sel == 7) begin
      put_word(i_type(12'(rand_range(16) * 4), 5'd1, 3'b010, pick_rd(), 7'b0000011));
    end else begin
      skip = 1 + rand_range(2);
      put_word(b_type(13'((skip + 1) * 4), pick_rs(), pick_rs(), 3'(rand_range(2))));
      repeat (skip) put_alu();
    end
  end
  // Dump the working registers
  for (int k = 2; k <= 12; k++) begin
    put_word(s_type(12'(128 + k * 4), 5'(k), 5'd1));
  end
  // Poll the keypad until an event shows up, back edge is -4
  put_word(i_type(12'd0, 5'd15, 3'b010, 5'd14, 7'b0000011));
  put_word(b_type(13'h1ffc, 5'd0, 5'd14, 3'b000));
  put_word(s_type(12'd68, 5'd14, 5'd1));
  put_word(u_type(20'(DONE_ADDR >> 12), 5'd13));
  put_word(s_type(12'd0, 5'd0, 5'd13));
  put_word(j_type(21'd0, 5'd0));
endtask

task automatic run_model();
  logic [31:0] regs [32];
  logic [31:0] pc;
  logic [31:0] next;
  logic [31:0] ins;
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] imm_i;
  logic [31:0] addr;
  logic [31:0] res;
  logic        wr;
  logic        done;
  int          steps;
  for (int k = 0; k < 32; k++) begin
    regs[k] = '0;
  end
  pc    = '0;
  done  = 1'b0;
  steps = 0;
  exp_stores.delete();
  while (!done && steps < 20000) begin
    ins   = ref_mem[pc[13:2]];
    a     = regs[ins[19:15]];
    b     = regs[ins[24:20]];
    imm_i = {{20{ins[31]}}, ins[31:20]};
    next  = pc + 32'd4;
    res   = '0;
    wr    = 1'b0;
    case (ins[6:0])
      7'b0110011: begin
        wr = 1'b1;
        case (ins[14:12])
          3'b000:  res = ins[30] ? a - b : a + b;
          3'b010:  res = {31'b0, $signed(a) < $signed(b)};
          3'b100:  res = a ^ b;
          3'b110:  res = a | b;
          default: res = a & b;
        endcase
      end
      7'b0010011: begin
        wr = 1'b1;
        case (ins[14:12])
          3'b000:  res = a + imm_i;
          3'b100:  res = a ^ imm_i;
          3'b110:  res = a | imm_i;
          default: res = a & imm_i;
        endcase
      end
      7'b0110111: begin
        wr  = 1'b1;
        res = {ins[31:12], 12'b0};
      end
      7'b0000011: begin
        // Keypad read is taken as the poll that exits the loop
        wr   = 1'b1;
        addr = a + imm_i;
        res  = (addr == `RV_KEYPAD_ADDR) ? 32'(16 + key_row * 4 + key_col) :
               ref_mem[addr[13:2]];
      end
      7'b0100011: begin
        addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
        if (addr == DONE_ADDR) begin
          done = 1'b1;
        end else begin
          exp_stores.push_back({addr, b});
          ref_mem[addr[13:2]] = b;
        end
      end
      7'b1100011: begin
        if ((ins[14:12] == 3'b000 && a == b) || (ins[14:12] == 3'b001 && a != b)) begin
          next = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        end
      end
      7'b1101111: begin
        wr   = 1'b1;
        res  = pc + 32'd4;
        next = pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
      end
      default: begin
        wr = 1'b0;
      end
    endcase
    if (wr && ins[11:7] != 5'd0) begin
      regs[ins[11:7]] = res;
    end
    pc = next;
    steps++;
  end
endtask

`endif

// ==== verif/rv_cpu_tb.sv ====
// Testbench for the rv_cpu processor
`timescale 1ns/1ps
`include "rv_core_params.svh"

module rv_cpu_tb;
  import rv_core_pkg::*;

  localparam int          CLK_PERIOD      = 8;
  localparam int          RESET_CYCLES    = 16;
  localparam int          NUM_PROGS       = 8;
  localparam int          CYCLES_PER_PROG = 20000;
  localparam int          MEM_WORDS       = 4096;
  localparam logic [31:0] DONE_ADDR       = 32'h0000_3000;

  logic        clk;
  logic        rst_n_i;
  logic        bus_busy;
  logic [31:0] bus_rdata;
  logic [3:0]  rows;
  logic [3:0]  cols;
  rv_bus_req_t bus_req;

  int          seed;
  int          errors;
  int          stores_checked;
  int          prog_idx;
  int          prog_len;
  int          key_row;
  int          key_col;
  int          low_edges;
  int          wait_left;
  logic        done_seen;
  logic        tracking;
  logic        first_fetch;
  rv_bus_req_t held;
  logic [31:0] mem     [MEM_WORDS];
  logic [31:0] ref_mem [MEM_WORDS];
  logic [63:0] exp_stores [$];
  logic [63:0] act_stores [$];

  `include "rv_iss_model.svh"

  rv_cpu rv_cpu_inst (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .bus_busy_i  (bus_busy),
    .bus_rdata_i (bus_rdata),
    .rows_i      (rows),
    .bus_req_o   (bus_req),
    .cols_o      (cols)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Bus slave with busy high while idle and 0 to 3 more busy cycles per request
  always @(posedge clk) begin
    if (bus_req.read && bus_req.write) begin
      errors++;
      $display("[FAIL] %0t: bus read and write both high", $time);
    end
    if (!rst_n_i) begin
      // The first reset edge still shows the old request
      if (low_edges > 0 && (bus_req.read || bus_req.write)) begin
        errors++;
        $display("[FAIL] %0t: bus request active during reset", $time);
      end
      low_edges++;
      tracking = 1'b0;
      bus_busy <= 1'b1;
    end else begin
      if (low_edges > 0) begin
        if (bus_req.read || bus_req.write) begin
          errors++;
          $display("[FAIL] %0t: bus request active in first cycle after reset", $time);
        end
        first_fetch = 1'b1;
      end
      low_edges = 0;
      if (bus_req.read || bus_req.write) begin
        if (tracking && bus_req != held) begin
          errors++;
          $display("[FAIL] %0t: bus request changed before completion", $time);
        end
        if (!tracking) begin
          if (first_fetch && (!bus_req.read || bus_req.adr != 32'd0)) begin
            errors++;
            $display("[FAIL] %0t: first fetch after reset at %h", $time, bus_req.adr);
          end
          if (bus_req.sel != 4'hf) begin
            errors++;
            $display("[FAIL] %0t: bus select %h is not all ones", $time, bus_req.sel);
          end
          first_fetch = 1'b0;
          held        = bus_req;
          tracking    = 1'b1;
          wait_left   = rand_range(4);
          bus_rdata <= mem[bus_req.adr[13:2]];
          bus_busy  <= (wait_left != 0);
        end else if (!bus_busy) begin
          tracking = 1'b0;
          bus_busy <= 1'b1;
          if (bus_req.write && bus_req.adr == DONE_ADDR) begin
            done_seen <= 1'b1;
          end else if (bus_req.write) begin
            act_stores.push_back({bus_req.adr, bus_req.dat});
            mem[bus_req.adr[13:2]] = bus_req.dat;
          end
        end else begin
          wait_left--;
          bus_busy <= (wait_left != 0);
        end
      end else begin
        bus_busy <= 1'b1;
      end
    end
  end

  // Keypad with one pressed key
  always @(posedge clk) begin
    if (rst_n_i && $countones(~cols) != 1) begin
      errors++;
      $display("[FAIL] %0t: keypad columns %b do not have exactly one low", $time, cols);
    end
    rows <= (cols[key_col] == 1'b0) ? ~(4'b0001 << key_row) : 4'hf;
  end

  task automatic compare_stores();
    int n;
    n = (act_stores.size() < exp_stores.size()) ? act_stores.size() : exp_stores.size();
    for (int i = 0; i < n; i++) begin
      if (act_stores[i] != exp_stores[i]) begin
        errors++;
        $display("[FAIL] %0t: program %0d store %0d wrote %h to %h, expected %h to %h",
                 $time, prog_idx, i, act_stores[i][31:0], act_stores[i][63:32],
                 exp_stores[i][31:0], exp_stores[i][63:32]);
      end
    end
    stores_checked += n;
    if (act_stores.size() != exp_stores.size()) begin
      errors++;
      $display("Program %0d made %0d stores but the model expects %0d",
               prog_idx, act_stores.size(), exp_stores.size());
    end
  endtask

  initial begin
    seed           = 94902;
    errors         = 0;
    stores_checked = 0;
    prog_idx       = 0;
    prog_len       = 0;
    key_row        = 0;
    key_col        = 0;
    low_edges      = 0;
    wait_left      = 0;
    tracking       = 1'b0;
    first_fetch    = 1'b0;
    done_seen      = 1'b0;
    rst_n_i        = 1'b0;
    bus_busy       = 1'b1;
    bus_rdata      = '0;
    rows           = 4'hf;
    for (int p = 0; p < NUM_PROGS; p++) begin
      prog_idx = p;
      rst_n_i   <= 1'b0;
      done_seen <= 1'b0;
      @(posedge clk);
      key_row = rand_range(4);
      key_col = rand_range(4);
      build_program();
      run_model();
      act_stores.delete();
      repeat (RESET_CYCLES - 1) @(posedge clk);
      rst_n_i <= 1'b1;
      while (!done_seen) begin
        @(posedge clk);
      end
      compare_stores();
    end
    $display("Summary: %0d stores checked, %0d errors", stores_checked, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  initial begin
    #(NUM_PROGS * CYCLES_PER_PROG * CLK_PERIOD);
    $display("Watchdog expired, the processor never reached the done store");
    $display("Errors found");
    $finish;
  end

endmodule

// ==== rv_cpu.f ====
+incdir+logic
+incdir+verif
logic/rv_core_pkg.sv
logic/instr_decoder.sv
logic/reg_file.sv
logic/core_datapath.sv
logic/request_unit.sv
logic/keypad_scanner.sv
logic/rv_cpu.sv
verif/rv_cpu_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the rv_cpu testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log
SIM_BIN=rv_cpu_sim

verilator --binary --timing -Wno-fatal --top-module rv_cpu_tb \
  -f rv_cpu.f --Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "No errors" "$LOG_FILE"; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed"
  exit 1
fi
